/* coreMemory.f */
+incdir+include
rtl/sbusPkg.sv
rtl/memCorePkg.sv
rtl/requestDecode.sv
rtl/wordSequencer.sv
rtl/responseDriver.sv
rtl/coreMemory.sv
tb/coreMemoryTb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := coreMemoryTb
FILELIST := coreMemory.f
OBJDIR   := obj_dir
PASS     := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR) -o $(TOP)
	@out="$$(./$(OBJDIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(OBJDIR)

/* tb/coreMemoryTb.sv */
`timescale 1ns/1ps
`include "coreMemory_settings.svh"

// Testbench for the SBUS core memory.
// Every table entry is one transfer, write data comes from an LFSR and a
// reference array keeps what the memory is expected to hold
module coreMemoryTb;
  import sbusPkg::*;

  localparam int NUM_ENTRIES = 11;
  localparam int CLK_PERIOD  = 20;
  localparam int ARRAY_WORDS = 1 << `MEM_ADDR_BITS;

  // One transfer and the acknowledges it should produce
  typedef struct {
    logic    wrRq;
    rqMask   rq;
    physAddr adr;
    int      expAcks;
    // Raise a second start in the middle of this transfer
    logic    startWhileBusy;
  } tableEntry;

  logic        SBUS;
  logic        rstN;
  sbusRequest  request;
  sbusResponse response;

  tableEntry   stim [NUM_ENTRIES];
  memWord      refMem [0:ARRAY_WORDS-1];
  logic [15:0] lfsrState;

  coreMemory dut0 (
    .SBUS     (SBUS),
    .rstN     (rstN),
    .request  (request),
    .response (response)
  );

  always #(CLK_PERIOD / 2) SBUS = ~SBUS;

  // Fibonacci LFSR with taps 16, 14, 13 and 11.
  // Each call takes one bit and steps the register once
  function automatic logic lfsrBit();
    logic fb;
    fb        = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrBit   = lfsrState[15];
    lfsrState = {lfsrState[14:0], fb};
  endfunction

  // A full word takes 36 steps, first bit taken lands in bit 0
  function automatic memWord lfsrWord();
    memWord w;
    w = '0;
    for (int i = 0; i < 36; i++) begin
      w = {w[1:35], lfsrBit()};
    end
    return w;
  endfunction

  // Array index of the word served for request bit bitPos.
  // The offset counts up from the start offset and wraps inside the quadword
  function automatic int wordIndex(input physAddr adr, input int bitPos);
    int base;
    int offset;
    base   = int'(adr) & (ARRAY_WORDS - 4);
    offset = (int'(adr) + bitPos) & 3;
    return base + offset;
  endfunction

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic checkWord(input memWord actual, input memWord expected, input string what);
    if (actual !== expected) begin
      failRun($sformatf("Error %0d ns: %s is %h, expected %h", $time, what, actual, expected));
    end
  endtask

  task automatic checkCount(input int actual, input int expected, input string what);
    if (actual != expected) begin
      failRun($sformatf("Error %0d ns: %s is %0d, expected %0d", $time, what, actual, expected));
    end
  endtask

  task automatic checkFlag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      failRun($sformatf("Error %0d ns: %s is %b, expected %b", $time, what, actual, expected));
    end
  endtask

  // Quad 0x1230 is written in full, then read back in several ways.
  // Quad 0x2abc4 gets the starts raised while the memory is busy
  task automatic fillTable();
    stim[0]  = '{1'b1, 4'b1111, 22'h001230, 4, 1'b0};
    stim[1]  = '{1'b0, 4'b1111, 22'h001230, 4, 1'b0};
    stim[2]  = '{1'b0, 4'b1111, 22'h001232, 4, 1'b0};
    stim[3]  = '{1'b0, 4'b1010, 22'h001230, 2, 1'b0};
    stim[4]  = '{1'b0, 4'b0001, 22'h001231, 1, 1'b0};
    stim[5]  = '{1'b1, 4'b0100, 22'h001230, 1, 1'b0};
    stim[6]  = '{1'b0, 4'b1111, 22'h001230, 4, 1'b0};
    stim[7]  = '{1'b0, 4'b0000, 22'h001230, 0, 1'b0};
    stim[8]  = '{1'b1, 4'b1111, 22'h2abc4, 4, 1'b1};
    stim[9]  = '{1'b0, 4'b1111, 22'h2abc4, 4, 1'b1};
    stim[10] = '{1'b0, 4'b1101, 22'h2abc7, 3, 1'b0};
  endtask

  // Runs one transfer, starting and ending on a falling edge
  task automatic runEntry(input tableEntry e, input int num);
    int    addrList [4];
    int    numAddr;
    int    ackCount;
    int    validCount;
    int    cycle;
    int    limit;
    int    quiet;
    logic  dataDue;
    logic  done;
    string tag;

    tag        = $sformatf("entry %0d", num);
    numAddr    = 0;
    ackCount   = 0;
    validCount = 0;
    cycle      = 0;
    dataDue    = 1'b0;
    done       = 1'b0;
    limit      = 3 + `ACCESS_LATENCY + 2 * 4 + 4;

    // Words are served in request bit order, so this is the expected address order
    for (int i = 0; i < 4; i++) begin
      if (e.rq[i]) begin
        addrList[numAddr] = wordIndex(e.adr, i);
        numAddr++;
      end
    end

    request.start = 1'b1;
    request.wrRq  = e.wrRq;
    request.rq    = e.rq;
    request.adr   = e.adr;

    while (!done) begin
      @(negedge SBUS);
      cycle++;
      request.start = 1'b0;

      // Write data belongs in the cycle after its acknowledge
      if (dataDue) begin
        request.dataIn = lfsrWord();
        if (ackCount <= numAddr) begin
          refMem[addrList[ackCount - 1]] = request.dataIn;
        end
        dataDue = 1'b0;
      end

      // A start raised in the middle of the transfer has to be dropped
      if (e.startWhileBusy && cycle == `ACCESS_LATENCY + 3) begin
        request.start = 1'b1;
        request.rq    = 4'b0011;
        request.adr   = e.adr ^ 22'h000100;
      end

      if (e.wrRq) begin
        checkFlag(response.dataValid, 1'b0, {tag, " dataValid during a write"});
      end
      if (response.ackn) begin
        ackCount++;
        dataDue = e.wrRq;
      end
      if (response.dataValid) begin
        // Sample number cycle shows the flops after edge cycle-1, counted
        // from the rising edge that took start
        if (validCount == 0) begin
          checkCount(cycle - 1, 3 + `ACCESS_LATENCY, {tag, " cycles to first dataValid"});
        end
        if (validCount < numAddr) begin
          checkWord(response.dataOut, refMem[addrList[validCount]],
                    $sformatf("%s word %0d", tag, validCount));
        end
        validCount++;
      end

      if (ackCount >= e.expAcks && !dataDue && (e.wrRq || validCount >= e.expAcks)) begin
        done = 1'b1;
      end
      if (cycle >= limit) begin
        done = 1'b1;
      end
    end

    // Extra strobes after the expected ones would show up here.
    // An empty request gets a longer window to prove that nothing comes
    quiet = (e.expAcks == 0) ? `ACCESS_LATENCY + 10 : 4;
    repeat (quiet) begin
      @(negedge SBUS);
      request.start = 1'b0;
      if (response.ackn) begin
        ackCount++;
      end
      if (response.dataValid) begin
        validCount++;
      end
    end

    checkCount(ackCount, e.expAcks, {tag, " acknowledge count"});
    checkCount(validCount, e.wrRq ? 0 : e.expAcks, {tag, " dataValid count"});
  endtask

  initial begin
    SBUS       = 1'b0;
    rstN       = 1'b0;
    request    = '0;
    lfsrState  = 16'd61582;
    fillTable();

    // Three rising edges with reset low
    repeat (3) @(negedge SBUS);
    rstN = 1'b1;
    @(negedge SBUS);

    // Bus lines are quiet before any request
    checkFlag(response.ackn, 1'b0, "ackn after reset");
    checkFlag(response.dataValid, 1'b0, "dataValid after reset");
    checkWord(response.dataOut, '0, "dataOut after reset");

    for (int n = 0; n < NUM_ENTRIES; n++) begin
      runEntry(stim[n], n);
    end

    $display("Simulation completed successfully");
    $finish;
  end

  // Generous bound per entry, plus room for the reset cycles
  initial begin
    #(NUM_ENTRIES * (`ACCESS_LATENCY + 12) * CLK_PERIOD * 2 + 10 * CLK_PERIOD);
    $display("Watchdog expired before all table entries were run");
    $display("Simulation failed");
    $fatal(1);
  end

endmodule

/* rtl/coreMemory.sv */
`timescale 1ns/1ps

// Core memory module on the SBUS.
// Decode checks the start strobe, the sequencer serves the words from the
// array, and the response driver puts them on the bus
module coreMemory (
  input  logic                 SBUS,
  input  logic                 rstN,
  input  sbusPkg::sbusRequest  request,
  output sbusPkg::sbusResponse response
);
  import memCorePkg::*;

  memCommand cmd;
  wordEvent  evt;
  logic      busy;

  requestDecode decode0 (
    .SBUS    (SBUS),
    .rstN    (rstN),
    .request (request),
    .busy    (busy),
    .cmd     (cmd)
  );

  // Write data goes straight from the bus to the array
  wordSequencer seq0 (
    .SBUS   (SBUS),
    .rstN   (rstN),
    .cmd    (cmd),
    .dataIn (request.dataIn),
    .busy   (busy),
    .evt    (evt)
  );

  responseDriver resp0 (
    .SBUS     (SBUS),
    .rstN     (rstN),
    .evt      (evt),
    .response (response)
  );

endmodule

/* rtl/responseDriver.sv */
`timescale 1ns/1ps

// Result stage of the core memory.
// All SBUS lines driven by the memory come straight from flops, one cycle
// after the event from the sequencer
module responseDriver (
  input  logic                 SBUS,
  input  logic                 rstN,
  input  memCorePkg::wordEvent evt,
  output sbusPkg::sbusResponse response
);

  always_ff @(posedge SBUS) begin
    if (!rstN) begin
      response.ackn      <= 1'b0;
      response.dataValid <= 1'b0;
      response.dataOut   <= '0;
    end else begin
      response.ackn      <= evt.ackPulse;
      response.dataValid <= evt.readValid;
      // Data lines only move on a read strobe and stay put otherwise
      if (evt.readValid) begin
        response.dataOut <= evt.readData;
      end
    end
  end

  // The master tells a word from its acknowledge by timing alone
  acknWithValid: assert property (
    @(posedge SBUS) disable iff (!rstN)
    !(response.ackn && response.dataValid)
  ) else $error("ackn and dataValid high together on the SBUS");

  // For a read the data strobe comes exactly one cycle after ackn
  validAfterAckn: assert property (
    @(posedge SBUS) disable iff (!rstN)
    response.dataValid |-> $past(response.ackn)
  ) else $error("dataValid without an ackn in the cycle before");

endmodule

/* rtl/wordSequencer.sv */
`timescale 1ns/1ps
`include "coreMemory_settings.svh"

// Execute stage of the core memory.
// It waits out the access latency and then walks the request mask, one
// ACK cycle and one XFER cycle for every bit that is set
module wordSequencer (
  input  logic                  SBUS,
  input  logic                  rstN,
  input  memCorePkg::memCommand cmd,
  input  sbusPkg::memWord       dataIn,
  output logic                  busy,
  output memCorePkg::wordEvent  evt
);
  import sbusPkg::*;
  import memCorePkg::*;

  // The core array itself
  memWord mem [0:(1 << `MEM_ADDR_BITS) - 1];

  seqState     state;
  latencyCount latCount;
  // Remaining request bits, with the word being served in bit 0
  rqMask       mask;
  wordOffset   offset;
  logic        write;
  physAddr     quadBase;
  memWord      readWord;
  // Write data shows up one cycle after XFER, so the capture is delayed
  logic        wrPending;
  memIndex     wrAddr;
  memIndex     wordAddr;
  rqMask       remaining;
  wordOffset   lead;
  wordOffset   skip;

  // Number of clear bits ahead of the first set bit.
  // An empty mask gives 3, and that result is never used
  function automatic wordOffset leadZeros(input rqMask m);
    if (m[0]) return 2'd0;
    if (m[1]) return 2'd1;
    if (m[2]) return 2'd2;
    return 2'd3;
  endfunction

  // The offset wraps within the quadword
  assign wordAddr  = {quadBase[36-`MEM_ADDR_BITS:33], offset};
  assign remaining = mask << 1;
  assign lead      = leadZeros(mask);
  assign skip      = leadZeros(remaining);

  always_ff @(posedge SBUS) begin
    if (!rstN) begin
      state     <= IDLE;
      busy      <= 1'b0;
      latCount  <= '0;
      mask      <= '0;
      offset    <= '0;
      wrPending <= 1'b0;
    end else begin
      wrPending <= (state == XFER) && write;
      case (state)
        IDLE: begin
          if (cmd.valid) begin
            // The latency cycles all follow the cycle that carried cmd.valid
            state    <= LATENCY;
            busy     <= 1'b1;
            latCount <= latencyCount'(`ACCESS_LATENCY - 1);
            mask     <= cmd.rq;
            offset   <= cmd.offset;
          end
        end
        LATENCY: begin
          if (latCount == '0) begin
            // Clear bits in front are skipped here, in the same cycle
            state  <= ACK;
            mask   <= mask << lead;
            offset <= offset + lead;
          end else begin
            latCount <= latCount - latencyCount'(1);
          end
        end
        ACK: begin
          state <= XFER;
        end
        XFER: begin
          if (remaining == '0) begin
            state <= IDLE;
            busy  <= 1'b0;
          end else begin
            state  <= ACK;
            mask   <= remaining << skip;
            offset <= offset + wordOffset'(1) + skip;
          end
        end
        default: begin
          state <= IDLE;
          busy  <= 1'b0;
        end
      endcase
    end
  end

  // Array ports and captured command fields
  always_ff @(posedge SBUS) begin
    if ((state == IDLE) && cmd.valid) begin
      write    <= cmd.write;
      quadBase <= cmd.quadBase;
    end
    // Read during ACK so the word is ready for XFER
    if (state == ACK) begin
      readWord <= mem[wordAddr];
    end
    if (state == XFER) begin
      wrAddr <= wordAddr;
    end
    if (wrPending) begin
      mem[wrAddr] <= dataIn;
    end
  end

  assign evt.ackPulse  = (state == ACK);
  assign evt.readValid = (state == XFER) && !write;
  assign evt.readData  = readWord;

  // busy is kept as its own register and has to track the state machine
  busyMatchesState: assert property (
    @(posedge SBUS) disable iff (!rstN)
    (state == IDLE) == !busy
  ) else $error("busy disagrees with the sequencer state");

  // An acknowledge and its read data always fall in separate cycles
  ackWithData: assert property (
    @(posedge SBUS) disable iff (!rstN)
    !(evt.ackPulse && evt.readValid)
  ) else $error("ackPulse and readValid high together");

endmodule

/* rtl/requestDecode.sv */
`timescale 1ns/1ps

// Decode stage of the core memory.
// A start strobe is checked and turned into a command that is valid for exactly
// one cycle, one clock after start was sampled
module requestDecode (
  input  logic                  SBUS,
  input  logic                  rstN,
  input  sbusPkg::sbusRequest   request,
  input  logic                  busy,
  output memCorePkg::memCommand cmd
);
  import sbusPkg::*;

  // Address split into the quadword base and the starting word
  physAddr   quadBase;
  wordOffset startOffset;
  logic      accept;

  assign quadBase    = {request.adr[14:33], 2'b00};
  assign startOffset = request.adr[34:35];

  // The sequencer only raises busy the cycle after cmd.valid, so a command
  // that is still on its way blocks a new one as well.
  // A request with no bits set would serve nothing and is dropped here
  assign accept = request.start && !busy && !cmd.valid && (request.rq != '0);

  always_ff @(posedge SBUS) begin
    if (!rstN) begin
      cmd.valid <= 1'b0;
    end else begin
      cmd.valid <= accept;
    end

    // Command fields only mean something while valid is high
    if (accept) begin
      cmd.write    <= request.wrRq;
      cmd.rq       <= request.rq;
      cmd.quadBase <= quadBase;
      cmd.offset   <= startOffset;
    end
  end

  // A command must never reach the sequencer while it is still serving the
  // previous one, since the sequencer would silently lose it
  cmdWhileBusy: assert property (
    @(posedge SBUS) disable iff (!rstN)
    cmd.valid |-> !busy
  ) else $error("Command issued while the sequencer is busy");

endmodule

/* rtl/memCorePkg.sv */
`include "coreMemory_settings.svh"

// Types internal to the core memory controller
package memCorePkg;

  // Sequencer states.
  // LATENCY models the core access time, then ACK and XFER alternate per word
  typedef enum logic [1:0] {
    IDLE,
    LATENCY,
    ACK,
    XFER
  } seqState;

  // Counter wide enough to hold the access latency
  typedef logic [$clog2(`ACCESS_LATENCY)-1:0] latencyCount;

  // Index into the word array
  typedef logic [`MEM_ADDR_BITS-1:0] memIndex;

  // A checked request as handed from decode to execute
  typedef struct packed {
    logic               valid;
    logic               write;
    sbusPkg::rqMask     rq;
    // Address with the offset bits cleared
    sbusPkg::physAddr   quadBase;
    sbusPkg::wordOffset offset;
  } memCommand;

  // What execute produces in a given cycle
  typedef struct packed {
    logic            ackPulse;
    logic            readValid;
    sbusPkg::memWord readData;
  } wordEvent;

endpackage

/* rtl/sbusPkg.sv */
// Types seen on the SBUS between a master and the core memory.
// Bit numbering follows the KL10, so bit 0 is the most significant bit
package sbusPkg;

  // One 36-bit memory word as carried on the SBUS data lines
  typedef logic [0:35] memWord;

  // A 22-bit physical word address.
  // Bits 34:35 give the word within the quadword where the transfer starts
  typedef logic [14:35] physAddr;

  // Position of a word inside a quadword
  typedef logic [0:1] wordOffset;

  // Request bits, one for each word of the quadword.
  // Bit 0 is the first word served, then bit 1 and so on
  typedef logic [0:3] rqMask;

  // Lines driven by the master.
  // start is a one-cycle strobe that is only raised while the memory is idle
  typedef struct packed {
    // Begins a transfer when high for one cycle
    logic    start;
    // Set for a write, clear for a read
    logic    wrRq;
    // Words wanted from the quadword
    rqMask   rq;
    // Quadword address and starting offset
    physAddr adr;
    // Write data, valid in the cycle after each acknowledge
    memWord  dataIn;
  } sbusRequest;

  // Lines driven by the memory.
  // There is no back-pressure, so the master must take each strobe as it comes
  typedef struct packed {
    // One cycle per word that is served
    logic   ackn;
    // Read data strobe, one cycle after the matching acknowledge
    logic   dataValid;
    // Read data, held at the last read word between strobes
    memWord dataOut;
  } sbusResponse;

endpackage

/* include/coreMemory_settings.svh */
`ifndef CORE_MEMORY_SETTINGS_SVH
`define CORE_MEMORY_SETTINGS_SVH

// Low address bits that index the array, giving 256K words
`define MEM_ADDR_BITS 18

// Cycles from a decoded command to the first acknowledge.
// The sequencer needs at least 2
`define ACCESS_LATENCY 4

`endif
